// File: sources.f
+incdir+rtl
rtl/rv32_pkg.sv
rtl/reg_file.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/apb_exec_port.sv
rtl/rv32_exec_top.sv
tests/tb_rv32_exec.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, verdict from $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_rv32_exec \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_rv32_exec.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module tb_rv32_exec import rv32_pkg::*; ();

    localparam int NUM_RANDOM  = 400;
    localparam int NUM_ILLEGAL = 40;
    localparam int TIMEOUT_NS  = 2000 * 3 * 4 + 8000;  // transfer budget plus margin

    logic                        clock;
    logic                        reset;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`APB_ADDR_WIDTH-1:0]  paddr;
    logic [`XLEN-1:0]            pwdata;
    logic [`XLEN-1:0]            prdata;
    logic                        pready;
    logic                        pslverr;

    logic [`XLEN-1:0] model_regs [0:`REG_COUNT-1];  // x0 is never written
    logic [`XLEN-1:0] model_retired;
    logic [31:0]      lcg_state;
    int               data_errors;
    int               flag_errors;

    rv32_exec_top u_rv32_exec_top (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish in time", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

    // two steps, upper halves only since the low bits of an lcg repeat quickly
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic logic [2:0] funct3_of(input alu_op_t op);
        case (op)
            ALU_SLL:          return 3'b001;
            ALU_SLT:          return 3'b010;
            ALU_SLTU:         return 3'b011;
            ALU_XOR:          return 3'b100;
            ALU_SRL, ALU_SRA: return 3'b101;
            ALU_OR:           return 3'b110;
            ALU_AND:          return 3'b111;
            default:          return 3'b000;  // add and sub
        endcase
    endfunction

    function automatic instr_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
        instr_t word;
        word.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP};
        return word;
    endfunction

    function automatic instr_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
        instr_t word;
        word.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: OPC_OP_IMM};
        return word;
    endfunction

    // reference results straight from the rv32i definitions
    function automatic logic [`XLEN-1:0] model_alu(input alu_op_t op,
                                                   input logic [`XLEN-1:0] a,
                                                   input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return (a[31] != b[31]) ? `XLEN'(a[31]) : `XLEN'(a < b);
            ALU_SLTU: return `XLEN'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    task automatic check_data(input string name, input logic [`XLEN-1:0] actual,
                              input logic [`XLEN-1:0] expected);
        if (actual !== expected) begin
            data_errors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
                     expected);
        end
    endtask

    task automatic check_error(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flag_errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual,
                     expected);
        end
    endtask

    // setup, access, then idle; three falling edges per transfer
    task automatic apb_transfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                                input logic [`XLEN-1:0] wdata,
                                output logic [`XLEN-1:0] rdata, output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin  // wait states, the watchdog bounds this
            @(negedge clock);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_reg(input logic [4:0] idx);
        logic [`XLEN-1:0] data;
        logic             err;
        apb_transfer(1'b0, `ADDR_REG_BASE + 8'(4 * idx), '0, data, err);
        check_error($sformatf("pslverr on read of x%0d", idx), err, 1'b0);
        check_data($sformatf("x%0d", idx), data, model_regs[idx]);
    endtask

    task automatic check_counter();
        logic [`XLEN-1:0] data;
        logic             err;
        apb_transfer(1'b0, `ADDR_RETIRED, '0, data, err);
        check_error("pslverr on counter read", err, 1'b0);
        check_data("retired", data, model_retired);
    endtask

    task automatic sweep_all();
        for (int i = 0; i < `REG_COUNT; i++) begin
            check_reg(5'(i));
        end
        check_counter();
    endtask

    task automatic run_legal(input int count, input logic to_x0);
        logic [31:0]      r;
        alu_op_t          op;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [11:0]      imm12;
        logic             use_imm;
        logic             shift;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] unused;
        logic             err;
        instr_t           word;
        for (int n = 0; n < count; n++) begin
            op = alu_op_t'(4'(next_rand() % 10));
            r = next_rand();
            rd = to_x0 ? 5'd0 : r[4:0];
            rs1 = r[9:5];
            use_imm = r[15] && (op != ALU_SUB);  // no subi in rv32i
            shift = (op == ALU_SLL) || (op == ALU_SRL) || (op == ALU_SRA);
            imm12 = r[27:16];
            if (use_imm) begin
                if (shift) begin
                    imm12 = {(op == ALU_SRA) ? 7'h20 : 7'h00, r[20:16]};
                    b = {27'b0, imm12[4:0]};
                end else begin
                    b = {{20{imm12[11]}}, imm12};
                end
                word = encode_i(imm12, rs1, funct3_of(op), rd);
            end else begin
                b = model_regs[r[14:10]];
                word = encode_r((op == ALU_SUB || op == ALU_SRA) ? 7'h20 : 7'h00,
                                r[14:10], rs1, funct3_of(op), rd);
            end
            if (rd != 5'd0) begin
                model_regs[rd] = model_alu(op, model_regs[rs1], b);
            end
            model_retired++;
            apb_transfer(1'b1, `ADDR_INSTR, word, unused, err);
            check_error($sformatf("pslverr on %s", op.name()), err, 1'b0);
            check_reg(rd);
        end
        if (to_x0) begin
            check_counter();
        end
    endtask

    task automatic run_illegal(input int count);
        logic [31:0]      r;
        logic [6:0]       upper;
        logic [2:0]       f3;
        logic [`XLEN-1:0] unused;
        logic             err;
        instr_t           word;
        for (int n = 0; n < count; n++) begin
            r = next_rand();
            word = next_rand();
            upper = r[14:8];
            f3 = r[4:2];
            case (r[1:0])
                2'd0: begin  // foreign opcode
                    if (word.r.opcode == OPC_OP || word.r.opcode == OPC_OP_IMM) begin
                        word[6] = ~word[6];
                    end
                end
                2'd1: begin  // funct7 outside the two valid values
                    if (upper == 7'h00 || upper == 7'h20) upper = upper | 7'h01;
                    word = encode_r(upper, word.r.rs2, word.r.rs1, f3, word.r.rd);
                end
                2'd2: begin  // alternate funct7 on an op that has no alternate
                    if (f3 == 3'b000 || f3 == 3'b101) f3 = f3 + 3'd1;
                    word = encode_r(7'h20, word.r.rs2, word.r.rs1, f3, word.r.rd);
                end
                default: begin  // shift immediate with bad upper bits
                    f3 = r[2] ? 3'b101 : 3'b001;
                    if (upper == 7'h00 || (upper == 7'h20 && f3 == 3'b101)) begin
                        upper = upper | 7'h02;
                    end
                    word = encode_i({upper, r[19:15]}, word.i.rs1, f3, word.i.rd);
                end
            endcase
            apb_transfer(1'b1, `ADDR_INSTR, word, unused, err);
            check_error($sformatf("pslverr on illegal word %h", word), err, 1'b1);
            check_reg(word.r.rd);
            check_counter();
        end
    endtask

    task automatic run_bus_errors();
        logic [`XLEN-1:0] data;
        logic             err;
        logic [4:0]       idx;
        for (int n = 0; n < 8; n++) begin
            idx = 5'(next_rand());
            apb_transfer(1'b1, `ADDR_REG_BASE + 8'(4 * idx), next_rand(), data, err);
            check_error($sformatf("pslverr on write to x%0d", idx), err, 1'b1);
            check_reg(idx);
        end
        apb_transfer(1'b1, `ADDR_RETIRED, 32'hffff_ffff, data, err);
        check_error("pslverr on counter write", err, 1'b1);
        check_counter();
        apb_transfer(1'b0, `ADDR_INSTR, '0, data, err);
        check_error("pslverr on instruction read", err, 1'b1);
        for (int n = 0; n < 8; n++) begin
            // alternate between the hole above the map and misaligned register offsets
            data = next_rand();
            if (n[0]) begin
                apb_transfer(1'b0, 8'h88 + 8'(data % 32'h78), '0, data, err);
            end else begin
                apb_transfer(1'b0, {1'b0, data[6:2], 2'b00} | 8'(1 + data[9:8] % 3), '0,
                             data, err);
            end
            check_error("pslverr on unmapped read", err, 1'b1);
        end
    endtask

    initial begin
        reset         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        lcg_state     = 32'd44;
        data_errors   = 0;
        flag_errors   = 0;
        model_retired = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(negedge clock);
        reset = 1'b1;

        sweep_all();                       // everything zero out of reset
        run_legal(NUM_RANDOM, 1'b0);
        run_legal(8, 1'b1);                // results dropped, count still moves
        run_illegal(NUM_ILLEGAL);
        run_bus_errors();
        sweep_all();

        $display("errors: %0d data mismatches, %0d pslverr mismatches", data_errors,
                 flag_errors);
        if (data_errors == 0 && flag_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: rtl/rv32_exec_top.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module rv32_exec_top import rv32_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`XLEN-1:0]            pwdata,
    output logic [`XLEN-1:0]            prdata,
    output logic                        pready,
    output logic                        pslverr
);

    instr_t             instr;
    logic               issue;
    logic               legal;
    logic               read_sel;
    logic [4:0]         reg_sel;
    logic [4:0]         dec_rs1;
    logic [4:0]         dec_rs2;
    logic [4:0]         dec_rd;
    logic [4:0]         read_index;
    logic [`XLEN-1:0]   imm;
    logic               use_imm;
    alu_op_t            alu_op;
    logic [`XLEN-1:0]   read_data_1;
    logic [`XLEN-1:0]   read_data_2;
    logic [`XLEN-1:0]   operand_b;
    logic [`XLEN-1:0]   result;

    assign read_index = read_sel ? reg_sel : dec_rs1;  // host read wins the port
    assign operand_b  = use_imm ? imm : read_data_2;

    apb_exec_port u_apb_exec_port (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .legal(legal), .reg_data(read_data_1),
        .instr(instr), .issue(issue), .reg_sel(reg_sel), .read_sel(read_sel)
    );

    instr_decoder u_instr_decoder (
        .instr(instr), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(imm),
        .use_imm(use_imm), .alu_op(alu_op), .legal(legal)
    );

    reg_file u_reg_file (
        .clock(clock), .reset(reset), .write(issue), .rd(dec_rd),
        .write_data(result), .rs1(read_index), .rs2(dec_rs2),
        .read_data_1(read_data_1), .read_data_2(read_data_2)
    );

    alu u_alu (
        .alu_op(alu_op), .operand_a(read_data_1), .operand_b(operand_b), .result(result)
    );

endmodule

// File: rtl/apb_exec_port.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module apb_exec_port import rv32_pkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`XLEN-1:0]            pwdata,
    output logic [`XLEN-1:0]            prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        legal,
    input  logic [`XLEN-1:0]            reg_data,
    output instr_t                      instr,
    output logic                        issue,
    output logic [4:0]                  reg_sel,
    output logic                        read_sel
);

    logic [`APB_ADDR_WIDTH-1:0] reg_offset;
    logic                       reg_hit;
    logic                       instr_hit;
    logic                       retired_hit;
    logic                       access;
    logic [`XLEN-1:0]           retired;

    // address map decode
    assign reg_offset  = paddr - `ADDR_REG_BASE;
    assign reg_hit     = (reg_offset[1:0] == 2'b00) &&
                         (reg_offset < `APB_ADDR_WIDTH'(4 * `REG_COUNT));
    assign instr_hit   = (paddr == `ADDR_INSTR);
    assign retired_hit = (paddr == `ADDR_RETIRED);

    assign access   = psel && penable;
    assign read_sel = psel && !pwrite;     // steers read port 1 to the host
    assign reg_sel  = reg_offset[6:2];
    assign instr    = pwdata;

    assign issue  = access && pwrite && instr_hit && legal;
    assign pready = 1'b1;                  // no wait states

    always_comb begin
        pslverr = 1'b0;
        if (access) begin
            if (pwrite) begin
                pslverr = !instr_hit || !legal;
            end else begin
                pslverr = !(reg_hit || retired_hit);
            end
        end
    end

    assign prdata = retired_hit ? retired :
                    reg_hit     ? reg_data : '0;

    // counts at the same edge that writes rd
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            retired <= '0;
        end else if (issue) begin
            retired <= retired + 1'b1;
        end
    end

endmodule

// File: rtl/alu.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module alu import rv32_pkg::*; (
    input  alu_op_t            alu_op,
    input  logic [`XLEN-1:0]   operand_a,
    input  logic [`XLEN-1:0]   operand_b,
    output logic [`XLEN-1:0]   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = operand_b[4:0];  // only low five bits shift
    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_SLL:  result = operand_a << shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_SRL:  result = operand_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt); // sign fill
            ALU_OR:   result = operand_a | operand_b;
            ALU_AND:  result = operand_a & operand_b;
            default:  result = '0;
        endcase
    end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module instr_decoder import rv32_pkg::*; (
    input  instr_t             instr,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [4:0]         rd,
    output logic [`XLEN-1:0]   imm,
    output logic               use_imm,
    output alu_op_t            alu_op,
    output logic               legal
);

    logic [2:0] funct3;
    logic       is_shift;

    // alt selects sub over add and sra over srl
    function automatic alu_op_t map_op(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: map_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     map_op = ALU_SLL;
            F3_SLT:     map_op = ALU_SLT;
            F3_SLTU:    map_op = ALU_SLTU;
            F3_XOR:     map_op = ALU_XOR;
            F3_SRL_SRA: map_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      map_op = ALU_OR;
            default:    map_op = ALU_AND;
        endcase
    endfunction

    assign rs1      = instr.r.rs1;
    assign rs2      = instr.r.rs2;
    assign rd       = instr.r.rd;
    assign funct3   = instr.r.funct3;
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    always_comb begin
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        legal   = 1'b0;
        imm     = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm}; // sign extended
        case (instr.r.opcode)
            OPC_OP: begin
                alu_op = map_op(funct3, instr.r.funct7[5]);
                // funct7 bit 5 only for sub and sra
                legal  = (instr.r.funct7 == F7_BASE) ||
                         (instr.r.funct7 == F7_ALT &&
                          (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                alu_op  = map_op(funct3, (funct3 == F3_SRL_SRA) && instr.i.imm[10]);
                if (is_shift) begin
                    imm = {{(`XLEN-5){1'b0}}, instr.i.imm[4:0]}; // shamt
                    // upper imm bits act as funct7 for the shifts
                    legal = (instr.i.imm[11:5] == F7_BASE) ||
                            (instr.i.imm[11:5] == F7_ALT && funct3 == F3_SRL_SRA);
                end else begin
                    legal = 1'b1;
                end
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/100ps
`include "rv32_consts.svh"

module reg_file (
    input  logic               clock,
    input  logic               reset,
    input  logic               write,
    input  logic [4:0]         rd,
    input  logic [`XLEN-1:0]   write_data,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    output logic [`XLEN-1:0]   read_data_1,
    output logic [`XLEN-1:0]   read_data_2
);

    // x1..x31 only, x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                if (write && rd == 5'(i)) begin  // rd of 0 matches nothing
                    regs[i] <= write_data;
                end
            end
        end
    end

    // read muxes, index 0 falls through to zero
    always_comb begin
        read_data_1 = '0;
        read_data_2 = '0;
        for (int i = 1; i < `REG_COUNT; i++) begin
            if (rs1 == 5'(i)) begin
                read_data_1 = regs[i];
            end
            if (rs2 == 5'(i)) begin
                read_data_2 = regs[i];
            end
        end
    end

endmodule

// File: rtl/rv32_pkg.sv
package rv32_pkg;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000  // sub, sra, srai
    } funct7_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_format_t;

    // opcode, rd, funct3 and rs1 line up in both views
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_t;

endpackage

// File: rtl/rv32_consts.svh
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

// datapath
`define XLEN            32
`define REG_COUNT       32

// apb address map, byte addresses
`define APB_ADDR_WIDTH  8
`define ADDR_REG_BASE   8'h00   // x0 here, xn at base + 4n
`define ADDR_INSTR      8'h80   // write only, issues one instruction
`define ADDR_RETIRED    8'h84   // read only, retired count

`endif
